// ==== Bender.yml ====
package:
  name: integra

sources:
  # package first, then the RTL bottom up
  - hw/integraPkg.sv
  - hw/busDecoder.sv
  - hw/pagingRegs.sv
  - hw/palPromPager.sv
  - hw/bankMapper.sv
  - hw/integraTop.sv
  - target: simulation
    files:
      - dv/integraAssert.sv
      - dv/integraTb.sv

// ==== dv/integraAssert.sv ====
`timescale 1ns/1ps

module integraAssert (
	input logic       phi2,
	input logic       rnw,
	input logic       nRamCe,
	input logic       nRomBankSelLow,
	input logic [7:0] nRomBankSel,
	input logic       nWds
);

	int failCount = 0;

	// sampled at the end of phi2, where the whole cycle has settled
	// RAM and any ROM never drive the bus together
	ramRomExcl: assert property (@(negedge phi2)
		!(!nRamCe && (!nRomBankSelLow || nRomBankSel != 8'hFF)))
	else begin
		failCount++;
		$error("RAM and a ROM socket selected in the same cycle");
	end

	// write strobe only on CPU writes
	wdsOnWrite: assert property (@(negedge phi2) !(!nWds && rnw))
	else begin
		failCount++;
		$error("nWds low during a read cycle");
	end

	// at most one on-board ROM socket
	oneRomSel: assert property (@(negedge phi2) $countones(~nRomBankSel) <= 1)
	else begin
		failCount++;
		$error("more than one nRomBankSel line low");
	end

endmodule

// ==== dv/integraTb.sv ====
`timescale 1ns/1ps

module integraTb;

	localparam int PalSlot = 11;
	// about 110 bus cycles of 3 clocks plus reset, so under 400 clocks
	localparam int MaxCycles = 2000;

	logic       cc4Clk;
	logic       bbc_nRST;
	logic       rnw;
	logic       phi2;
	logic       phi2End;
	logic [15:0] address;
	logic [7:0] data;
	logic [3:0] beebRomSel;
	logic [7:0] integraRomSel;
	logic       nRamCe;
	logic [4:0] ramAddress;
	logic       nRomBankSelLow;
	logic [7:0] nRomBankSel;
	logic       nRds;
	logic       nWds;
	logic       nDBufCe;
	logic       bbcRnW;
	logic       palRead;

	// reference copy of the paging state
	logic [3:0] mSlot;
	logic       mPrvEn;
	logic       mMemSel;
	logic       mPrvS1;
	logic       mPrvS4;
	logic       mPrvS8;
	logic       mShEn;
	logic [15:0] mWe;
	int         mPal;

	// expected and captured outputs of the current bus cycle
	logic       eNRamCe, eNRomLow, eNRds, eNWds, eNDBufCe, eBbcRnW, ePalRead;
	logic [4:0] eRamAddr;
	logic [7:0] eNRomSel;
	logic       cNRamCe, cNRomLow, cNRds, cNWds, cNDBufCe, cBbcRnW, cPalRead;
	logic [4:0] cRamAddr;
	logic [7:0] cNRomSel;

	logic [31:0] seed;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int assertFails;

	integraTop #(
		.PalSlot (PalSlot)
	) DUT (
		.cc4Clk         (cc4Clk),
		.bbc_nRST       (bbc_nRST),
		.rnw            (rnw),
		.phi2           (phi2),
		.phi2End        (phi2End),
		.address        (address),
		.data           (data),
		.beebRomSel     (beebRomSel),
		.integraRomSel  (integraRomSel),
		.nRamCe         (nRamCe),
		.ramAddress     (ramAddress),
		.nRomBankSelLow (nRomBankSelLow),
		.nRomBankSel    (nRomBankSel),
		.nRds           (nRds),
		.nWds           (nWds),
		.nDBufCe        (nDBufCe),
		.bbcRnW         (bbcRnW),
		.palRead        (palRead)
	);

	// output consistency checks sit inside the mapper
	bind bankMapper integraAssert uAssert (
		.phi2           (phi2),
		.rnw            (rnw),
		.nRamCe         (nRamCe),
		.nRomBankSelLow (nRomBankSelLow),
		.nRomBankSel    (nRomBankSel),
		.nWds           (nWds)
	);

	initial begin
		cc4Clk = 1'b0;
		forever #2 cc4Clk = ~cc4Clk;
	end

	// run limit
	always @(posedge cc4Clk) begin
		cycles <= cycles + 1;
		if (cycles >= MaxCycles) begin
			$display("Timeout: the run did not finish within %0d clock cycles", MaxCycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] randWord();
		seed = xorshift(seed);
		return seed;
	endfunction

	// expected memory outputs while phi2 is high
	function automatic void predict(input logic [15:0] a, input logic r);
		logic shadow;
		logic priv;
		logic sw;
		int   slot;
		shadow = (a >= 16'h3000) && (a <= 16'h7FFF) && mShEn && !mMemSel;
		priv = mPrvEn && (((a >= 16'h8000) && (a <= 16'h83FF) && mPrvS1) ||
			((a >= 16'h8000) && (a <= 16'h8FFF) && mPrvS4) ||
			((a >= 16'h9000) && (a <= 16'hAFFF) && mPrvS8));
		sw = (a >= 16'h8000) && (a <= 16'hBFFF);
		slot = mSlot;
		eNRamCe = 1'b1;
		eRamAddr = 5'd0;
		eNRomLow = 1'b1;
		eNRomSel = 8'hFF;
		eNWds = 1'b1;
		ePalRead = 1'b0;
		if (shadow || priv) begin
			// shadow block, never write protected
			eNRamCe = 1'b0;
			eRamAddr = a[14] ? 5'd17 : 5'd16;
			eNWds = r;
		end else if (sw) begin
			if (slot < 4 && beebRomSel[slot]) begin
				eNRomLow = 1'b0;
			end else if (slot >= 8 && integraRomSel[slot-8]) begin
				eNRomSel[slot-8] = 1'b0;
			end else begin
				eNRamCe = 1'b0;
				eRamAddr = slot;
				if (slot == PalSlot) begin
					ePalRead = r;
					if (mPal != 0) begin
						eRamAddr = 25 + mPal - 1;
					end
				end
				eNWds = !(!r && mWe[slot]);
			end
		end
		eNRds = !r;
		eNDBufCe = !(!eNRamCe || eNRomSel != 8'hFF || a[15:4] == 12'hFE3);
		eBbcRnW = r || shadow;
	endfunction

	// register writes and PALPROM switching at the end of a cycle
	task automatic updateModel(input logic [15:0] a, input logic [7:0] d, input logic r);
		if (!r && a[15:4] == 12'hFE3) begin
			case (a[3:0])
				4'h0, 4'h1, 4'h2, 4'h3: begin
					mSlot = d[3:0];
					mPrvEn = d[6];
					mMemSel = d[7];
				end
				4'h4, 4'h5, 4'h6, 4'h7: begin
					mPrvS8 = d[4];
					mPrvS4 = d[5];
					mPrvS1 = d[6];
					mShEn = d[7];
				end
				4'hA: mWe[7:0] = d;
				4'hB: mWe[15:8] = d;
				default: ;
			endcase
		end
		if (ePalRead && a[15:8] == 8'hBF) begin
			// BFE0 block goes home, the others page only from base
			if (a[7:5] == 3'd7) begin
				mPal = 0;
			end else if (mPal == 0) begin
				mPal = 7 - a[7:5];
			end
		end
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic compareOutputs();
		check("nRamCe", cNRamCe, eNRamCe);
		// bank number only matters while the RAM is selected
		if (!eNRamCe) begin
			check("ramAddress", cRamAddr, eRamAddr);
		end
		check("nRomBankSelLow", cNRomLow, eNRomLow);
		check("nRomBankSel", cNRomSel, eNRomSel);
		check("nRds", cNRds, eNRds);
		check("nWds", cNWds, eNWds);
		check("nDBufCe", cNDBufCe, eNDBufCe);
		check("bbcRnW", cBbcRnW, eBbcRnW);
		check("palRead", cPalRead, ePalRead);
	endtask

	// one CPU cycle, two clocks with phi2 high, phi2End in the second
	task automatic busCycle(input logic [15:0] a, input logic [7:0] d, input logic r);
		@(negedge cc4Clk);
		address = a;
		data = d;
		rnw = r;
		phi2 = 1'b1;
		phi2End = 1'b0;
		predict(a, r);
		// combinational outputs settle well before the rising edge
		#1;
		cNRamCe = nRamCe;
		cRamAddr = ramAddress;
		cNRomLow = nRomBankSelLow;
		cNRomSel = nRomBankSel;
		cNRds = nRds;
		cNWds = nWds;
		cNDBufCe = nDBufCe;
		cBbcRnW = bbcRnW;
		cPalRead = palRead;
		compareOutputs();
		@(negedge cc4Clk);
		phi2End = 1'b1;
		@(negedge cc4Clk);
		phi2End = 1'b0;
		phi2 = 1'b0;
		rnw = 1'b1;
		updateModel(a, d, r);
	endtask

	task automatic resetTest();
		beebRomSel = 4'h0;
		integraRomSel = 8'h00;
		// slot 0 is RAM and every slot starts protected
		busCycle(16'h8000, 8'h5A, 1'b0);
		check("nWds", cNWds, 1'b1);
		beebRomSel = 4'h1;
		busCycle(16'h8000, 8'h00, 1'b1);
		check("nRomBankSelLow", cNRomLow, 1'b0);
	endtask

	task automatic slotTest();
		logic [31:0] r;
		logic [31:0] ra;
		repeat (12) begin
			r = randWord();
			ra = randWord();
			beebRomSel = r[11:8];
			integraRomSel = r[19:12];
			// any mirror of FE30..FE33, private and memsel left clear
			busCycle(16'hFE30 + r[21:20], {2'b00, r[5:0]}, 1'b0);
			busCycle(16'h8000 + ra[12:0], ra[23:16], 1'b1);
			if (!eNRamCe) begin
				check("ramAddress", cRamAddr, {1'b0, r[3:0]});
			end
		end
	endtask

	task automatic wpTest();
		logic [31:0] r;
		logic [31:0] ra;
		int          s;
		beebRomSel = 4'h0;
		integraRomSel = 8'h00;
		r = randWord();
		busCycle(16'hFE3A, r[7:0], 1'b0);
		busCycle(16'hFE3B, r[15:8], 1'b0);
		for (s = 0; s < 16; s++) begin
			ra = randWord();
			busCycle(16'hFE30, 8'(s), 1'b0);
			busCycle(16'h8000 + ra[12:0], ra[23:16], 1'b0);
			// write strobe only for slots with their enable bit set
			check("nWds", cNWds, !r[s]);
		end
	endtask

	task automatic shadowTest();
		logic [15:0] probes [6] = '{16'h8000, 16'h8400, 16'h8FFF, 16'h9000, 16'hAFFF, 16'hB000};
		logic [7:0]  flags [3] = '{8'h40, 8'h20, 8'h10};
		logic [31:0] r;
		beebRomSel = 4'h0;
		integraRomSel = 8'h00;
		busCycle(16'hFE30, 8'h00, 1'b0);
		busCycle(16'hFE34, 8'h80, 1'b0);
		// shadow writes stay off the motherboard RAM
		busCycle(16'h3000, 8'hAA, 1'b0);
		check("ramAddress", cRamAddr, 5'd16);
		check("bbcRnW", cBbcRnW, 1'b1);
		busCycle(16'h7FFF, 8'h55, 1'b0);
		check("ramAddress", cRamAddr, 5'd17);
		check("bbcRnW", cBbcRnW, 1'b1);
		repeat (6) begin
			r = randWord();
			busCycle(16'h3000 + (r[15:0] % 16'h5000), r[23:16], r[24]);
		end
		// memsel gives the screen back to the motherboard
		busCycle(16'hFE30, 8'h80, 1'b0);
		busCycle(16'h5000, 8'h00, 1'b0);
		check("nRamCe", cNRamCe, 1'b1);
		check("bbcRnW", cBbcRnW, 1'b0);
		// private enable with slot 12 as RAM behind the windows
		busCycle(16'hFE30, 8'h4C, 1'b0);
		foreach (flags[f]) begin
			busCycle(16'hFE34, flags[f], 1'b0);
			foreach (probes[p]) begin
				busCycle(probes[p], 8'h00, 1'b1);
			end
		end
		busCycle(16'hFE34, 8'h00, 1'b0);
		busCycle(16'hFE30, 8'h00, 1'b0);
	endtask

	task automatic palTest();
		beebRomSel = 4'h0;
		integraRomSel = 8'h00;
		busCycle(16'hFE30, 8'(PalSlot), 1'b0);
		busCycle(16'hBFE0, 8'h00, 1'b1);
		busCycle(16'hBFC0, 8'h00, 1'b1);
		// ignored, not at base any more
		busCycle(16'hBF00, 8'h00, 1'b1);
		busCycle(16'h8000, 8'h00, 1'b1);
		check("ramAddress", cRamAddr, 5'd25);
		check("palRead", cPalRead, 1'b1);
		busCycle(16'hBFE0, 8'h00, 1'b1);
		busCycle(16'hBF00, 8'h00, 1'b1);
		busCycle(16'h8000, 8'h00, 1'b1);
		check("ramAddress", cRamAddr, 5'd31);
		busCycle(16'hBFE0, 8'h00, 1'b1);
	endtask

	task automatic regTest();
		logic [31:0] r;
		r = randWord();
		// FE3C has no register behind it
		busCycle(16'hFE3C, r[7:0], 1'b0);
		check("nDBufCe", cNDBufCe, 1'b0);
		busCycle(16'hFE30 + r[11:8], 8'h00, 1'b1);
		check("nDBufCe", cNDBufCe, 1'b0);
	endtask

	initial begin
		bbc_nRST = 1'b0;
		rnw = 1'b1;
		// CPU clock idles high through reset
		phi2 = 1'b1;
		phi2End = 1'b0;
		address = 16'h0000;
		data = 8'h00;
		beebRomSel = 4'h0;
		integraRomSel = 8'h00;
		seed = 32'h4df7fe5c;
		mSlot = 4'h0;
		mPrvEn = 1'b0;
		mMemSel = 1'b0;
		mPrvS1 = 1'b0;
		mPrvS4 = 1'b0;
		mPrvS8 = 1'b0;
		mShEn = 1'b0;
		mWe = 16'h0000;
		mPal = 0;
		repeat (4) @(posedge cc4Clk);
		@(negedge cc4Clk);
		bbc_nRST = 1'b1;
		phi2 = 1'b0;
		resetTest();
		slotTest();
		wpTest();
		shadowTest();
		palTest();
		regTest();
		@(negedge cc4Clk);
		assertFails = DUT.uBankMapper.uAssert.failCount;
		$display("Summary: %0d checks, %0d check errors, %0d assertion failures",
			checks, errors, assertFails);
		if (errors == 0 && assertFails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== hw/bankMapper.sv ====
`timescale 1ns/1ps

module bankMapper #(
	parameter int PalSlot = 11
) (
	input  logic                              rnw,
	input  logic                              phi2,
	input  logic                              address14,
	input  logic                              screenArea,
	input  logic                              swArea,
	input  logic [2:0]                        privArea,
	input  logic                              regPageHit,
	input  logic [integraPkg::SlotW-1:0]      romSlot,
	input  logic                              prvEn,
	input  logic                              memSel,
	input  logic                              prvS1,
	input  logic                              prvS4,
	input  logic                              prvS8,
	input  logic                              shEn,
	input  logic [integraPkg::NumSlots-1:0]   writeEnable,
	input  integraPkg::palBankE               palBank,
	input  logic [3:0]                        beebRomSel,
	input  logic [7:0]                        integraRomSel,
	output logic                              nRamCe,
	output logic [integraPkg::RamBankW-1:0]   ramAddress,
	output logic                              nRomBankSelLow,
	output logic [7:0]                        nRomBankSel,
	output logic                              nRds,
	output logic                              nWds,
	output logic                              nDBufCe,
	output logic                              bbcRnW,
	output logic                              palRead
);

	localparam int PadW = integraPkg::RamBankW - integraPkg::SlotW;
	localparam int PalPadW = integraPkg::RamBankW - integraPkg::PalBankW;

	logic shAct;
	logic prvAct;
	logic shadowSel;
	logic swSel;
	logic beebRom;
	logic integraRom;
	logic swRam;
	logic palActive;
	logic cpuRead;
	logic cpuWrite;

	assign cpuRead = rnw && phi2;
	assign cpuWrite = !rnw && phi2;

	// shadow screen, MEMSEL gives the CPU the main screen back
	assign shAct = screenArea && shEn && !memSel;

	// private RAM, each window gated by its own size flag
	assign prvAct = prvEn && ((privArea[0] && prvS1) ||
		(privArea[1] && prvS4) || (privArea[2] && prvS8));

	// both live in the 32K shadow block
	assign shadowSel = shAct || prvAct;

	// private RAM overrides whatever slot is paged in
	assign swSel = swArea && !prvAct;

	// slots 0..3 jumpered to motherboard ROM
	assign beebRom = swSel && (romSlot < 4) && beebRomSel[romSlot[1:0]];

	// slots 8..15 jumpered to the on-board ROM sockets
	assign integraRom = swSel && romSlot[3] && integraRomSel[romSlot[2:0]];

	// anything else in the sideways window is on-board RAM
	assign swRam = swSel && !beebRom && !integraRom;

	// emulated PALPROM slot
	assign palActive = swRam && (int'(romSlot) == PalSlot);
	assign palRead = palActive && cpuRead;

	always_comb begin
		if (shadowSel) begin
			// A14 picks the lower or upper 16K of the shadow block
			ramAddress = address14 ? integraPkg::ShadowHiBank : integraPkg::ShadowLoBank;
		end else if (palActive && (palBank != integraPkg::palBase)) begin
			// page k lands in bank PalExtBase + k - 1
			ramAddress = integraPkg::PalExtBase + {{PalPadW{1'b0}}, palBank} - 1'b1;
		end else begin
			// plain sideways RAM, bank number equals slot number
			ramAddress = {{PadW{1'b0}}, romSlot};
		end
	end

	assign nRamCe = !(shadowSel || swRam);

	// ROM selects are plain active low lines
	assign nRomBankSelLow = !beebRom;
	assign nRomBankSel = ~(integraRom ? (8'h01 << romSlot[2:0]) : 8'h00);

	assign nRds = !cpuRead;

	// soft write protect only covers sideways RAM
	// shadow and private writes always go through
	assign nWds = !(cpuWrite && (shadowSel || (swRam && writeEnable[romSlot])));

	// data buffer for on-board RAM, on-board ROM and the register page
	assign nDBufCe = !(shadowSel || swRam || integraRom || regPageHit);

	// keep motherboard RAM from seeing shadow writes
	assign bbcRnW = rnw || shAct;

endmodule

// ==== hw/busDecoder.sv ====
`timescale 1ns/1ps

module busDecoder (
	input  logic [15:0]         address,
	output integraPkg::regSelE  regSel,
	output logic                regPageHit,
	output logic                screenArea,
	output logic                swArea,
	output logic [2:0]          privArea,
	output logic [2:0]          palTrigger,
	output logic                palTriggerHit
);

	// FE3x register page
	assign regPageHit = (address[15:4] == integraPkg::RegPage);

	// FE30..FE33 and FE34..FE37 are mirrored over A1 and A0
	// the write protect pair needs the full nibble since they differ in A0
	always_comb begin
		regSel = integraPkg::regNone;
		if (regPageHit) begin
			if (address[3:2] == 2'b00) begin
				regSel = integraPkg::regRomSel;
			end else if (address[3:2] == 2'b01) begin
				regSel = integraPkg::regShadow;
			end else if (address[3:0] == 4'hA) begin
				regSel = integraPkg::regWpLow;
			end else if (address[3:0] == 4'hB) begin
				regSel = integraPkg::regWpHigh;
			end
		end
	end

	// screen memory 3000..7FFF
	assign screenArea = (address[15:12] == 4'h3) || (address[15:14] == 2'b01);

	// sideways window 8000..BFFF
	assign swArea = (address[15:14] == 2'b10);

	// private windows, the 1K one sits inside the 4K one
	// bit 0 is 8000..83FF, bit 1 is 8000..8FFF
	assign privArea[0] = (address[15:10] == 6'b1000_00);
	assign privArea[1] = (address[15:12] == 4'h8);
	// bit 2 is 9000..AFFF
	assign privArea[2] = (address[15:12] == 4'h9) || (address[15:12] == 4'hA);

	// PALPROM switch blocks, one per 32 bytes of page BF
	assign palTriggerHit = (address[15:8] == integraPkg::PalTriggerPage);
	assign palTrigger = address[7:5];

endmodule

// ==== hw/integraPkg.sv ====
package integraPkg;

	// sideways slot number and slot count
	localparam int SlotW = 4;
	localparam int NumSlots = 16;

	// 32 banks of 16K in the 512K RAM, bank number drives RAM A18..A14
	localparam int RamBankW = 5;

	// board registers live at FE30..FE3F
	localparam logic [11:0] RegPage = 12'hFE3;

	// shadow screen and private RAM share a 32K block
	localparam logic [RamBankW-1:0] ShadowLoBank = 5'd16;
	localparam logic [RamBankW-1:0] ShadowHiBank = 5'd17;

	// PALPROM pages 1..7 sit in banks 25..31, page 0 stays in the slot bank
	localparam logic [RamBankW-1:0] PalExtBase = 5'd25;

	// 32 byte blocks in BF00..BFFF switch the PALPROM pages
	localparam logic [7:0] PalTriggerPage = 8'hBF;

	localparam int PalBankW = 3;

	// register targets inside the FE3x page
	typedef enum logic [2:0] {
		regNone,
		regRomSel,
		regShadow,
		regWpLow,
		regWpHigh
	} regSelE;

	// active 16K page of the 128K PALPROM
	typedef enum logic [PalBankW-1:0] {
		palBase,
		palPage1,
		palPage2,
		palPage3,
		palPage4,
		palPage5,
		palPage6,
		palPage7
	} palBankE;

endpackage

// ==== hw/integraTop.sv ====
`timescale 1ns/1ps

module integraTop #(
	parameter int PalSlot = 11
) (
	input  logic                             cc4Clk,
	input  logic                             bbc_nRST,
	input  logic                             rnw,
	input  logic                             phi2,
	input  logic                             phi2End,
	input  logic [15:0]                      address,
	input  logic [7:0]                       data,
	input  logic [3:0]                       beebRomSel,
	input  logic [7:0]                       integraRomSel,
	output logic                             nRamCe,
	output logic [integraPkg::RamBankW-1:0]  ramAddress,
	output logic                             nRomBankSelLow,
	output logic [7:0]                       nRomBankSel,
	output logic                             nRds,
	output logic                             nWds,
	output logic                             nDBufCe,
	output logic                             bbcRnW,
	output logic                             palRead
);

	// decoder outputs
	integraPkg::regSelE regSel;
	logic               regPageHit;
	logic               screenArea;
	logic               swArea;
	logic [2:0]         privArea;
	logic [2:0]         palTrigger;
	logic               palTriggerHit;

	// held paging state
	logic [integraPkg::SlotW-1:0]     romSlot;
	logic                             prvEn;
	logic                             memSel;
	logic                             prvS1;
	logic                             prvS4;
	logic                             prvS8;
	logic                             shEn;
	logic [integraPkg::NumSlots-1:0]  writeEnable;
	integraPkg::palBankE              palBank;

	busDecoder uBusDecoder (
		.address       (address),
		.regSel        (regSel),
		.regPageHit    (regPageHit),
		.screenArea    (screenArea),
		.swArea        (swArea),
		.privArea      (privArea),
		.palTrigger    (palTrigger),
		.palTriggerHit (palTriggerHit)
	);

	pagingRegs uPagingRegs (
		.cc4Clk      (cc4Clk),
		.bbc_nRST    (bbc_nRST),
		.rnw         (rnw),
		.phi2End     (phi2End),
		.regSel      (regSel),
		.data        (data),
		.romSlot     (romSlot),
		.prvEn       (prvEn),
		.memSel      (memSel),
		.prvS1       (prvS1),
		.prvS4       (prvS4),
		.prvS8       (prvS8),
		.shEn        (shEn),
		.writeEnable (writeEnable)
	);

	// palRead comes back from the mapper, the pager only watches its slot
	palPromPager #(
		.PalSlot (PalSlot)
	) uPalPromPager (
		.cc4Clk        (cc4Clk),
		.bbc_nRST      (bbc_nRST),
		.phi2End       (phi2End),
		.palRead       (palRead),
		.palTrigger    (palTrigger),
		.palTriggerHit (palTriggerHit),
		.palBank       (palBank)
	);

	bankMapper #(
		.PalSlot (PalSlot)
	) uBankMapper (
		.rnw            (rnw),
		.phi2           (phi2),
		.address14      (address[14]),
		.screenArea     (screenArea),
		.swArea         (swArea),
		.privArea       (privArea),
		.regPageHit     (regPageHit),
		.romSlot        (romSlot),
		.prvEn          (prvEn),
		.memSel         (memSel),
		.prvS1          (prvS1),
		.prvS4          (prvS4),
		.prvS8          (prvS8),
		.shEn           (shEn),
		.writeEnable    (writeEnable),
		.palBank        (palBank),
		.beebRomSel     (beebRomSel),
		.integraRomSel  (integraRomSel),
		.nRamCe         (nRamCe),
		.ramAddress     (ramAddress),
		.nRomBankSelLow (nRomBankSelLow),
		.nRomBankSel    (nRomBankSel),
		.nRds           (nRds),
		.nWds           (nWds),
		.nDBufCe        (nDBufCe),
		.bbcRnW         (bbcRnW),
		.palRead        (palRead)
	);

endmodule

// ==== hw/pagingRegs.sv ====
`timescale 1ns/1ps

module pagingRegs (
	input  logic                              cc4Clk,
	input  logic                              bbc_nRST,
	input  logic                              rnw,
	input  logic                              phi2End,
	input  integraPkg::regSelE                regSel,
	input  logic [7:0]                        data,
	output logic [integraPkg::SlotW-1:0]      romSlot,
	output logic                              prvEn,
	output logic                              memSel,
	output logic                              prvS1,
	output logic                              prvS4,
	output logic                              prvS8,
	output logic                              shEn,
	output logic [integraPkg::NumSlots-1:0]   writeEnable
);

	localparam int HalfSlots = integraPkg::NumSlots / 2;

	logic cpuWrite;

	// CPU write completes in the last clock of the cycle
	assign cpuWrite = !rnw && phi2End;

	always_ff @(posedge cc4Clk) begin
		if (!bbc_nRST) begin
			romSlot <= '0;
			prvEn <= 1'b0;
			memSel <= 1'b0;
			prvS1 <= 1'b0;
			prvS4 <= 1'b0;
			prvS8 <= 1'b0;
			shEn <= 1'b0;
			// all slots write protected out of reset
			writeEnable <= '0;
		end else if (cpuWrite) begin
			case (regSel)
				integraPkg::regRomSel: begin
					// slot in D3..D0, private enable D6, memsel D7
					romSlot <= data[integraPkg::SlotW-1:0];
					prvEn <= data[6];
					memSel <= data[7];
				end
				integraPkg::regShadow: begin
					// private window sizes in D4..D6
					prvS8 <= data[4];
					prvS4 <= data[5];
					prvS1 <= data[6];
					// shadow screen enable
					shEn <= data[7];
				end
				integraPkg::regWpLow: begin
					// slots 0..7, a set bit allows writes
					writeEnable[HalfSlots-1:0] <= data;
				end
				integraPkg::regWpHigh: begin
					// slots 8..15
					writeEnable[integraPkg::NumSlots-1:HalfSlots] <= data;
				end
				default: begin
					// writes to FE38/FE39 and FE3C..F leave state alone
				end
			endcase
		end
	end

endmodule

// ==== hw/palPromPager.sv ====
`timescale 1ns/1ps

// 128K Computer Concepts style PALPROM held in RAM
// the base page lives in slot PalSlot, pages 1..7 in the extra banks
module palPromPager #(
	parameter int PalSlot = 11
) (
	input  logic                 cc4Clk,
	input  logic                 bbc_nRST,
	input  logic                 phi2End,
	input  logic                 palRead,
	input  logic [2:0]           palTrigger,
	input  logic                 palTriggerHit,
	output integraPkg::palBankE  palBank
);

	integraPkg::palBankE nextBank;
	logic                sampleEn;

	// only the on-board sockets 8..15 can host the image
	if (PalSlot < 8 || PalSlot > 15) begin : gSlotRange
		$error("palPromPager: PalSlot must be in 8..15");
	end

	// a read of slot PalSlot at the end of the CPU cycle
	assign sampleEn = palRead && phi2End && palTriggerHit;

	always_comb begin
		nextBank = palBank;
		// BFE0 block always returns to base
		if (palTrigger == 3'b111) begin
			nextBank = integraPkg::palBase;
		end else if (palBank == integraPkg::palBase) begin
			// paging only allowed from base, BFC0 down to BF00
			case (palTrigger)
				3'b110: nextBank = integraPkg::palPage1;
				3'b101: nextBank = integraPkg::palPage2;
				3'b100: nextBank = integraPkg::palPage3;
				3'b011: nextBank = integraPkg::palPage4;
				3'b010: nextBank = integraPkg::palPage5;
				3'b001: nextBank = integraPkg::palPage6;
				default: nextBank = integraPkg::palPage7;
			endcase
		end
	end

	always_ff @(posedge cc4Clk) begin
		if (!bbc_nRST) begin
			palBank <= integraPkg::palBase;
		end else if (sampleEn) begin
			palBank <= nextBank;
		end
	end

endmodule

// ==== tb.f ====
hw/integraPkg.sv
hw/busDecoder.sv
hw/pagingRegs.sv
hw/palPromPager.sv
hw/bankMapper.sv
hw/integraTop.sv
dv/integraAssert.sv
dv/integraTb.sv
